// ==== Makefile ====
# Verilator flow for the AXI write channel monitor

VERILATOR ?= verilator
TOP       ?= tb_axi_wr_mon
FILELIST  ?= axi_wr_mon.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All checks passed
VFLAGS    ?= --timing --assert -Wno-fatal

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o sim_$(TOP)
	./$(BUILD_DIR)/sim_$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== axi_wr_mon.f ====
+incdir+tests
hw/axi_wr_mon_pkg.sv
hw/aw_attr_queue.sv
hw/w_beat_tracker.sv
hw/strb_checker.sv
hw/wr_id_tracker.sv
hw/axi_wr_mon.sv
tests/tb_axi_wr_mon.sv

// ==== hw/aw_attr_queue.sv ====
`timescale 1ns/10ps

module aw_attr_queue #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  aw_valid_i,
    input  logic                  aw_ready_i,
    input  axi_wr_mon_pkg::addr_t aw_addr_i,
    input  axi_wr_mon_pkg::size_t aw_size_i,
    input  axi_wr_mon_pkg::len_t  aw_len_i,
    input  logic                  w_valid_i,
    input  logic                  w_ready_i,
    input  logic                  w_last_i,
    input  logic                  b_valid_i,
    input  logic                  b_ready_i,
    output logic                  aw_fire_o,
    output logic                  w_fire_o,
    output logic                  b_fire_o,
    output logic                  cur_valid_o,
    output axi_wr_mon_pkg::addr_t cur_addr_o,
    output axi_wr_mon_pkg::size_t cur_size_o,
    output axi_wr_mon_pkg::len_t  cur_len_o,
    output logic                  err_orphan_o,
    output logic                  err_overflow_o
);
    import axi_wr_mon_pkg::*;

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    addr_t addr_mem [QUEUE_DEPTH];
    size_t size_mem [QUEUE_DEPTH];
    len_t  len_mem  [QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
    logic [CNT_W-1:0] count_q;   // entries held, 0..QUEUE_DEPTH
    logic             empty, full;
    logic             push, pop;
    logic             byp_now;   // AW meets first W beat on an empty queue
    logic             byp_q;     // bypass burst still running on W
    logic             byp_sel;
    addr_t            byp_addr_q;
    size_t            byp_size_q;
    len_t             byp_len_q;
    logic             err_orphan_q, err_overflow_q;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;  // depth need not be 2**n
    endfunction

    assign aw_fire_o = aw_valid_i && aw_ready_i;
    assign w_fire_o  = w_valid_i && w_ready_i;
    assign b_fire_o  = b_valid_i && b_ready_i;

    assign empty   = (count_q == '0);
    assign full    = (count_q == CNT_W'(QUEUE_DEPTH));
    assign byp_now = empty && !byp_q && aw_fire_o && w_fire_o;
    assign byp_sel = byp_now || byp_q;

    assign push = aw_fire_o && !full && !byp_now;  // bypassed AW never enters the queue
    assign pop  = w_fire_o && w_last_i && !empty && !byp_sel;

    // attributes of the burst on W: live AW, held bypass, else queue head
    assign cur_valid_o = byp_sel || !empty;
    assign cur_addr_o  = byp_now ? aw_addr_i : (byp_q ? byp_addr_q : addr_mem[rd_ptr_q]);
    assign cur_size_o  = byp_now ? aw_size_i : (byp_q ? byp_size_q : size_mem[rd_ptr_q]);
    assign cur_len_o   = byp_now ? aw_len_i  : (byp_q ? byp_len_q  : len_mem[rd_ptr_q]);

    always_ff @(posedge clk_i) begin
        if (push) begin
            addr_mem[wr_ptr_q] <= aw_addr_i;
            size_mem[wr_ptr_q] <= aw_size_i;
            len_mem[wr_ptr_q]  <= aw_len_i;
        end
        if (byp_now) begin  // AW payload may change after the handshake
            byp_addr_q <= aw_addr_i;
            byp_size_q <= aw_size_i;
            byp_len_q  <= aw_len_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q       <= '0;
            rd_ptr_q       <= '0;
            count_q        <= '0;
            byp_q          <= 1'b0;
            err_orphan_q   <= 1'b0;
            err_overflow_q <= 1'b0;
        end else begin
            if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
            if (pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
            count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
            if (w_fire_o && w_last_i) begin
                byp_q <= 1'b0;  // single-beat bypass never sets it
            end else if (byp_now) begin
                byp_q <= 1'b1;
            end
            err_orphan_q   <= w_fire_o && !cur_valid_o;  // data with no address behind it
            err_overflow_q <= aw_fire_o && full;         // entry is dropped
        end
    end

    assign err_orphan_o   = err_orphan_q;
    assign err_overflow_o = err_overflow_q;

    a_count_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
        count_q <= CNT_W'(QUEUE_DEPTH));

endmodule

// ==== hw/axi_wr_mon.sv ====
`timescale 1ns/10ps

module axi_wr_mon #(
    parameter int QUEUE_DEPTH = 8,
    parameter int STRB_W      = axi_wr_mon_pkg::DEF_STRB_W
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  aw_valid_i,
    input  logic                  aw_ready_i,
    input  axi_wr_mon_pkg::addr_t aw_addr_i,
    input  axi_wr_mon_pkg::size_t aw_size_i,
    input  axi_wr_mon_pkg::len_t  aw_len_i,
    input  axi_wr_mon_pkg::id_t   aw_id_i,
    input  logic                  w_valid_i,
    input  logic                  w_ready_i,
    input  logic [STRB_W-1:0]     w_strb_i,
    input  logic                  w_last_i,
    input  logic                  b_valid_i,
    input  logic                  b_ready_i,
    input  axi_wr_mon_pkg::id_t   b_id_i,
    output logic                  err_wlast_o,
    output logic                  err_strb_o,
    output logic                  err_id_reuse_o,
    output logic                  err_bresp_o,
    output logic                  err_orphan_o,
    output logic                  err_overflow_o,
    output logic                  burst_done_o
);
    import axi_wr_mon_pkg::*;

    localparam int LANE_W = $clog2(STRB_W);

    logic              aw_fire, w_fire, b_fire;
    logic              cur_valid;  // a burst is open for the W beat
    addr_t             cur_addr;
    size_t             cur_size;
    len_t              cur_len;
    logic              first_beat;
    logic [LANE_W-1:0] lane_ptr;

    aw_attr_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
        .clk_i, .rst_ni,
        .aw_valid_i, .aw_ready_i, .aw_addr_i, .aw_size_i, .aw_len_i,
        .w_valid_i, .w_ready_i, .w_last_i,
        .b_valid_i, .b_ready_i,
        .aw_fire_o(aw_fire), .w_fire_o(w_fire), .b_fire_o(b_fire),
        .cur_valid_o(cur_valid), .cur_addr_o(cur_addr),
        .cur_size_o(cur_size), .cur_len_o(cur_len),
        .err_orphan_o, .err_overflow_o
    );

    w_beat_tracker #(.STRB_W(STRB_W)) u_beats (
        .clk_i, .rst_ni,
        .w_fire_i(w_fire), .w_last_i,
        .cur_valid_i(cur_valid), .cur_addr_i(cur_addr),
        .cur_size_i(cur_size), .cur_len_i(cur_len),
        .first_beat_o(first_beat), .lane_ptr_o(lane_ptr),
        .err_wlast_o, .burst_done_o
    );

    strb_checker #(.STRB_W(STRB_W)) u_strb (
        .clk_i, .rst_ni,
        .w_fire_i(w_fire), .w_strb_i,
        .cur_valid_i(cur_valid), .cur_addr_i(cur_addr), .cur_size_i(cur_size),
        .first_beat_i(first_beat), .lane_ptr_i(lane_ptr),
        .err_strb_o
    );

    // ID table sees raw AW/B IDs, it is independent of the W ordering
    wr_id_tracker u_ids (
        .clk_i, .rst_ni,
        .aw_fire_i(aw_fire), .aw_id_i,
        .b_fire_i(b_fire), .b_id_i,
        .err_id_reuse_o, .err_bresp_o
    );

endmodule

// ==== hw/axi_wr_mon_pkg.sv ====
package axi_wr_mon_pkg;

    // bus geometry of the observed slave port
    localparam int ADDR_W     = 64;
    localparam int ID_W       = 4;
    localparam int DEF_STRB_W = 8;  // 64-bit data bus, one strobe per byte

    // widths of the attribute fields kept per queued AW entry
    localparam int SIZE_W = 3;  // awsize code
    localparam int LEN_W  = 8;  // awlen, beats minus one

    // a queued entry is addr + size + len, the ID goes to the ID table instead

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [ID_W-1:0]   id_t;
    typedef logic [SIZE_W-1:0] size_t;  // beat carries 2**size bytes
    typedef logic [LEN_W-1:0]  len_t;   // 0 means a single beat

endpackage

// ==== hw/strb_checker.sv ====
`timescale 1ns/10ps

module strb_checker #(
    parameter int STRB_W = 8
) (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      w_fire_i,
    input  logic [STRB_W-1:0]         w_strb_i,
    input  logic                      cur_valid_i,
    input  axi_wr_mon_pkg::addr_t     cur_addr_i,
    input  axi_wr_mon_pkg::size_t     cur_size_i,
    input  logic                      first_beat_i,
    input  logic [$clog2(STRB_W)-1:0] lane_ptr_i,
    output logic                      err_strb_o
);
    localparam int LANE_W = $clog2(STRB_W);

    logic [LANE_W:0]   beat_bytes;
    logic [LANE_W-1:0] size_mask;
    logic [LANE_W-1:0] lo_lane;    // first lane touched by the start address
    logic [LANE_W-1:0] hi_lane;    // last lane of that address's container
    logic [STRB_W-1:0] exp_strb;
    logic              err_strb_q;

    assign beat_bytes = {{LANE_W{1'b0}}, 1'b1} << cur_size_i;
    assign size_mask  = LANE_W'(beat_bytes - 1'b1);
    assign lo_lane    = cur_addr_i[LANE_W-1:0];
    assign hi_lane    = lo_lane | size_mask;

    always_comb begin
        exp_strb = '0;
        for (int i = 0; i < STRB_W; i++) begin
            if (first_beat_i) begin
                // unaligned start only fills up to the container end
                exp_strb[i] = (i >= lo_lane) && (i <= hi_lane);
            end else begin
                exp_strb[i] = (i >= lane_ptr_i) && (i < lane_ptr_i + beat_bytes);
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            err_strb_q <= 1'b0;
        end else begin
            err_strb_q <= w_fire_i && cur_valid_i && (w_strb_i != exp_strb);  // any lane off
        end
    end

    assign err_strb_o = err_strb_q;

    // a beat wider than the bus would leave the lane math meaningless
    a_size_fits: assert property (@(posedge clk_i) disable iff (!rst_ni)
        w_fire_i && cur_valid_i |-> cur_size_i <= LANE_W);

endmodule

// ==== hw/w_beat_tracker.sv ====
`timescale 1ns/10ps

module w_beat_tracker #(
    parameter int STRB_W = 8
) (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          w_fire_i,
    input  logic                          w_last_i,
    input  logic                          cur_valid_i,
    input  axi_wr_mon_pkg::addr_t         cur_addr_i,
    input  axi_wr_mon_pkg::size_t         cur_size_i,
    input  axi_wr_mon_pkg::len_t          cur_len_i,
    output logic                          first_beat_o,
    output logic [$clog2(STRB_W)-1:0]     lane_ptr_o,
    output logic                          err_wlast_o,
    output logic                          burst_done_o
);
    import axi_wr_mon_pkg::*;

    localparam int LANE_W = $clog2(STRB_W);

    logic [LEN_W:0]    beat_cnt_q;   // one spare bit so a missing wlast is still seen
    logic [LANE_W-1:0] lane_ptr_q;
    logic [LANE_W:0]   beat_bytes;   // 2**size, fits since size <= LANE_W
    logic [LANE_W-1:0] size_mask;
    logic [LANE_W-1:0] aligned_off;  // address offset rounded down to the container
    logic              beat_ok;
    logic              err_wlast_q, burst_done_q;

    assign beat_bytes  = {{LANE_W{1'b0}}, 1'b1} << cur_size_i;
    assign size_mask   = LANE_W'(beat_bytes - 1'b1);
    assign aligned_off = cur_addr_i[LANE_W-1:0] & ~size_mask;

    assign first_beat_o = (beat_cnt_q == '0);
    assign beat_ok      = w_fire_i && cur_valid_i;  // orphan beats are left to the queue

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            beat_cnt_q   <= '0;
            lane_ptr_q   <= '0;
            err_wlast_q  <= 1'b0;
            burst_done_q <= 1'b0;
        end else begin
            if (w_fire_i && w_last_i) begin
                beat_cnt_q <= '0;  // burst closes on wlast, early or not
            end else if (beat_ok) begin
                beat_cnt_q <= beat_cnt_q + 1'b1;
            end
            if (beat_ok) begin
                // next beat's lane, wraps modulo the bus width
                lane_ptr_q <= (first_beat_o ? aligned_off : lane_ptr_q) + LANE_W'(beat_bytes);
            end
            // wlast only on beat number len, nowhere else
            err_wlast_q  <= beat_ok && (w_last_i != (beat_cnt_q == {1'b0, cur_len_i}));
            burst_done_q <= w_fire_i && w_last_i;
        end
    end

    assign lane_ptr_o   = lane_ptr_q;
    assign err_wlast_o  = err_wlast_q;
    assign burst_done_o = burst_done_q;

    // bursts longer than 256 beats cannot be described by awlen
    a_beat_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
        beat_cnt_q <= (LEN_W+1)'(255));

endmodule

// ==== hw/wr_id_tracker.sv ====
`timescale 1ns/10ps

module wr_id_tracker (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                aw_fire_i,
    input  axi_wr_mon_pkg::id_t aw_id_i,
    input  logic                b_fire_i,
    input  axi_wr_mon_pkg::id_t b_id_i,
    output logic                err_id_reuse_o,
    output logic                err_bresp_o
);
    import axi_wr_mon_pkg::*;

    localparam int NUM_IDS = 2 ** ID_W;

    logic [NUM_IDS-1:0] pend_q;     // one bit per ID with a write awaiting B
    logic               same_id;    // AW and B on one ID in one cycle
    logic               err_reuse_q, err_bresp_q;

    assign same_id = aw_fire_i && b_fire_i && (aw_id_i == b_id_i);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pend_q      <= '0;
            err_reuse_q <= 1'b0;
            err_bresp_q <= 1'b0;
        end else begin
            if (b_fire_i) pend_q[b_id_i] <= 1'b0;
            if (aw_fire_i) pend_q[aw_id_i] <= 1'b1;  // later write wins so the bit stays set
            // B is taken first, so a same-cycle AW sees the ID freed
            err_reuse_q <= aw_fire_i && pend_q[aw_id_i] && !same_id;
            err_bresp_q <= b_fire_i && !pend_q[b_id_i];
        end
    end

    assign err_id_reuse_o = err_reuse_q;
    assign err_bresp_o    = err_bresp_q;

    // an unknown ID would hit an unknown slot of the table
    a_aw_id_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
        aw_fire_i |-> !$isunknown(aw_id_i));
    a_b_id_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
        b_fire_i |-> !$isunknown(b_id_i));

endmodule

// ==== tests/tb_axi_wr_mon_ref.svh ====
// fibonacci LFSR, taps 32 22 2 1, shifts one bit per call
logic [31:0] lfsr_q = 32'hc872ce1e;

function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
endfunction

// n fresh bits, one LFSR step for each
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
        r = {r[30:0], lfsr_bit()};
    end
    return r;
endfunction

// lanes a beat may write, from the start address, size and beat number
function automatic logic [STRB_W-1:0] ref_strb(input addr_t addr, input size_t size,
                                               input int beat);
    int                nbytes;
    int                base;
    int                lo;
    int                hi;
    logic [STRB_W-1:0] m;
    nbytes = 1 << size;
    base   = int'(addr % STRB_W) / nbytes * nbytes;  // container start lane
    if (beat == 0) begin
        lo = int'(addr % STRB_W);  // unaligned start trims the low lanes
        hi = base + nbytes - 1;
    end else begin
        lo = (base + beat * nbytes) % STRB_W;
        hi = lo + nbytes - 1;
    end
    m = '0;
    for (int i = 0; i < STRB_W; i++) begin
        m[i] = (i >= lo) && (i <= hi);
    end
    return m;
endfunction

// model state
addr_t              q_addr[$];   // queued AW attributes, head is the burst on W
size_t              q_size[$];
len_t               q_len[$];
logic               m_byp;       // bypass burst still running on W
addr_t              m_byp_addr;
size_t              m_byp_size;
len_t               m_byp_len;
int                 m_beat;      // beat number inside the open burst
logic [2**ID_W-1:0] m_pend;      // IDs awaiting their B
logic               exp_wlast, exp_strb, exp_reuse, exp_bresp;
logic               exp_orphan, exp_overflow, exp_done;

task automatic model_reset();
    q_addr.delete();
    q_size.delete();
    q_len.delete();
    m_byp  = 1'b0;
    m_beat = 0;
    m_pend = '0;
    {exp_wlast, exp_strb, exp_reuse, exp_bresp, exp_orphan, exp_overflow, exp_done} = '0;
endtask

// one rising edge: predict the pulses of the next cycle, then move the state on
task automatic model_step();
    logic  aw, w, b, full, byp_now, open;
    addr_t a;
    size_t s;
    len_t  l;
    aw      = aw_valid_i && aw_ready_i;
    w       = w_valid_i && w_ready_i;
    b       = b_valid_i && b_ready_i;
    full    = (q_addr.size() == QUEUE_DEPTH);
    byp_now = (q_addr.size() == 0) && !m_byp && aw && w;  // AW meets its first beat
    open    = 1'b1;
    a       = '0;
    s       = '0;
    l       = '0;
    if (m_byp) begin
        a = m_byp_addr;
        s = m_byp_size;
        l = m_byp_len;
    end else if (q_addr.size() != 0) begin
        a = q_addr[0];
        s = q_size[0];
        l = q_len[0];
    end else if (byp_now) begin
        a = aw_addr_i;
        s = aw_size_i;
        l = aw_len_i;
    end else begin
        open = 1'b0;  // no address for this data
    end
    exp_orphan   = w && !open;
    exp_overflow = aw && full;
    exp_wlast    = w && open && (w_last_i != (m_beat == int'(l)));
    exp_strb     = w && open && (w_strb_i != ref_strb(a, s, m_beat));
    exp_done     = w && w_last_i;
    exp_reuse    = aw && m_pend[aw_id_i] && !(b && b_id_i == aw_id_i);
    exp_bresp    = b && !m_pend[b_id_i];
    if (w && w_last_i) begin
        m_beat = 0;
        if (!m_byp && !byp_now && q_addr.size() != 0) begin
            void'(q_addr.pop_front());
            void'(q_size.pop_front());
            void'(q_len.pop_front());
        end
        m_byp = 1'b0;
    end else if (w && open) begin
        m_beat++;
        if (byp_now) begin
            m_byp      = 1'b1;
            m_byp_addr = aw_addr_i;
            m_byp_size = aw_size_i;
            m_byp_len  = aw_len_i;
        end
    end
    if (aw && !full && !byp_now) begin
        q_addr.push_back(aw_addr_i);
        q_size.push_back(aw_size_i);
        q_len.push_back(aw_len_i);
    end
    if (b) m_pend[b_id_i] = 1'b0;
    if (aw) m_pend[aw_id_i] = 1'b1;  // set after clear, same-cycle B frees it first
endtask

// ==== tests/tb_axi_wr_mon.sv ====
`timescale 1ns/10ps

module tb_axi_wr_mon;
    import axi_wr_mon_pkg::*;

    localparam int QUEUE_DEPTH = 8;
    localparam int STRB_W      = DEF_STRB_W;
    localparam int NUM_BURSTS  = 12;                     // random full-width bursts
    localparam int MAX_BEATS   = NUM_BURSTS * 16 + 64;   // random lengths stay below 16
    localparam int WDOG_CYCLES = MAX_BEATS * 4 + 200;

    logic              clk_i = 1'b0;
    logic              rst_ni;
    logic              aw_valid_i, aw_ready_i, w_valid_i, w_ready_i, w_last_i;
    logic              b_valid_i, b_ready_i;
    addr_t             aw_addr_i;
    size_t             aw_size_i;
    len_t              aw_len_i;
    id_t               aw_id_i, b_id_i;
    logic [STRB_W-1:0] w_strb_i;
    logic              err_wlast_o, err_strb_o, err_id_reuse_o, err_bresp_o;
    logic              err_orphan_o, err_overflow_o, burst_done_o;

    len_t cnt_done, cnt_wlast, cnt_strb, cnt_reuse, cnt_bresp, cnt_orphan, cnt_overflow;
    int   inj_wlast, inj_strb, inj_reuse, inj_bresp, inj_orphan, inj_overflow, bursts_sent;
    int   flag_errs, count_errs;

    `include "tb_axi_wr_mon_ref.svh"

    axi_wr_mon #(.QUEUE_DEPTH(QUEUE_DEPTH), .STRB_W(STRB_W)) UUT (.*);

    always #50 clk_i = ~clk_i;  // 100 ns period

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            flag_errs++;
            $display("Error %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_count(input string name, input len_t got, input len_t exp);
        if (got !== exp) begin
            count_errs++;
            $display("Error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // all handshake tasks start and end on a falling edge
    task automatic send_aw(input addr_t a, input size_t s, input len_t l, input id_t id);
        {aw_valid_i, aw_addr_i, aw_size_i, aw_len_i, aw_id_i} = {1'b1, a, s, l, id};
        do begin
            aw_ready_i = (rand_bits(2) != 0);  // ready low about one cycle in four
            @(negedge clk_i);
        end while (!aw_ready_i);
        {aw_valid_i, aw_ready_i} = '0;
    endtask

    task automatic send_w(input logic [STRB_W-1:0] strb, input logic last);
        {w_valid_i, w_strb_i, w_last_i} = {1'b1, strb, last};
        do begin
            w_ready_i = (rand_bits(2) != 0);
            @(negedge clk_i);
        end while (!w_ready_i);
        {w_valid_i, w_ready_i, w_last_i} = '0;
    endtask

    task automatic send_b(input id_t id);
        {b_valid_i, b_id_i} = {1'b1, id};
        do begin
            b_ready_i = (rand_bits(2) != 0);
            @(negedge clk_i);
        end while (!b_ready_i);
        {b_valid_i, b_ready_i} = '0;
    endtask

    // beats 0..last_at with wlast on last_at and lane 0 inverted on beat flip_at
    task automatic send_burst(input addr_t a, input size_t s, input int last_at,
                              input int flip_at);
        logic [STRB_W-1:0] strb;
        for (int beat = 0; beat <= last_at; beat++) begin
            strb = ref_strb(a, s, beat);
            if (beat == flip_at) strb[0] = ~strb[0];
            send_w(strb, beat == last_at);
        end
        bursts_sent++;
    endtask

    task automatic full_burst(input addr_t a, input size_t s, input len_t l, input id_t id);
        send_aw(a, s, l, id);
        send_burst(a, s, int'(l), -1);
        send_b(id);
    endtask

    // AW and first beat in one cycle on an empty queue
    task automatic bypass_burst(input addr_t a, input size_t s, input len_t l, input id_t id);
        {aw_valid_i, aw_ready_i, aw_addr_i, aw_size_i, aw_len_i, aw_id_i} = {2'b11, a, s, l, id};
        {w_valid_i, w_ready_i, w_strb_i, w_last_i} = {2'b11, ref_strb(a, s, 0), l == 0};
        @(negedge clk_i);
        {aw_valid_i, aw_ready_i, w_valid_i, w_ready_i, w_last_i} = '0;
        {aw_addr_i, aw_size_i, aw_len_i} = '0;  // monitor has to use its held copy now
        for (int beat = 1; beat <= int'(l); beat++) begin
            send_w(ref_strb(a, s, beat), beat == int'(l));
        end
        bursts_sent++;
        send_b(id);
    endtask

    always @(posedge clk_i) begin
        if (!rst_ni) begin
            model_reset();
        end else begin
            model_step();
        end
    end

    // outputs settle after the rising edge and are compared half a cycle later
    always @(negedge clk_i) begin
        if (rst_ni) begin
            check_flag("err_wlast_o", err_wlast_o, exp_wlast);
            check_flag("err_strb_o", err_strb_o, exp_strb);
            check_flag("err_id_reuse_o", err_id_reuse_o, exp_reuse);
            check_flag("err_bresp_o", err_bresp_o, exp_bresp);
            check_flag("err_orphan_o", err_orphan_o, exp_orphan);
            check_flag("err_overflow_o", err_overflow_o, exp_overflow);
            check_flag("burst_done_o", burst_done_o, exp_done);
            cnt_done     += len_t'(burst_done_o);
            cnt_wlast    += len_t'(err_wlast_o);
            cnt_strb     += len_t'(err_strb_o);
            cnt_reuse    += len_t'(err_id_reuse_o);
            cnt_bresp    += len_t'(err_bresp_o);
            cnt_orphan   += len_t'(err_orphan_o);
            cnt_overflow += len_t'(err_overflow_o);
        end
    end

    initial begin
        repeat (WDOG_CYCLES) @(posedge clk_i);
        $display("Timeout: the run did not finish within %0d cycles", WDOG_CYCLES);
        $display("Checks failed");
        $finish;
    end

    initial begin
        {aw_valid_i, aw_ready_i, aw_addr_i, aw_size_i, aw_len_i, aw_id_i} = '0;
        {w_valid_i, w_ready_i, w_strb_i, w_last_i, b_valid_i, b_ready_i, b_id_i} = '0;
        {cnt_done, cnt_wlast, cnt_strb, cnt_reuse, cnt_bresp, cnt_orphan, cnt_overflow} = '0;
        {inj_wlast, inj_strb, inj_reuse, inj_bresp, inj_orphan, inj_overflow} = '0;
        {bursts_sent, flag_errs, count_errs} = '0;
        rst_ni = 1'b0;
        repeat (4) @(negedge clk_i);
        rst_ni = 1'b1;
        send_w('1, 1'b0);  // data before any address
        inj_orphan++;
        for (int i = 0; i < NUM_BURSTS; i++) begin
            full_burst(addr_t'(rand_bits(16)) << 3, 3'd3, len_t'(rand_bits(4)), id_t'(i));
        end
        send_aw(64'h100, 3'd3, 8'd3, 4'd1);  // wlast one beat early
        send_burst(64'h100, 3'd3, 1, -1);
        send_b(4'd1);
        send_aw(64'h200, 3'd3, 8'd1, 4'd2);  // wlast one beat late flags two beats
        send_burst(64'h200, 3'd3, 2, -1);
        send_b(4'd2);
        inj_wlast += 3;
        full_burst(64'h1003, 3'd1, 8'd5, 4'd3);  // narrow bursts with unaligned starts
        full_burst(64'h2005, 3'd2, 8'd3, 4'd4);
        full_burst(64'h3006, 3'd0, 8'd4, 4'd6);
        send_aw(64'h4005, 3'd2, 8'd3, 4'd7);
        send_burst(64'h4005, 3'd2, 3, 2);
        send_b(4'd7);
        send_aw(64'h5001, 3'd1, 8'd2, 4'd8);
        send_burst(64'h5001, 3'd1, 2, 0);
        send_b(4'd8);
        inj_strb += 2;
        bypass_burst(64'h6003, 3'd1, 8'd3, 4'd10);
        bypass_burst(64'h7010, 3'd3, 8'd0, 4'd11);
        send_aw(64'h8000, 3'd3, 8'd1, 4'd5);
        send_aw(64'h8100, 3'd3, 8'd0, 4'd5);  // ID 5 still open
        inj_reuse++;
        send_burst(64'h8000, 3'd3, 1, -1);
        send_burst(64'h8100, 3'd3, 0, -1);
        send_b(4'd5);
        send_b(4'd15);  // ID 15 was never written
        inj_bresp++;
        for (int i = 0; i <= QUEUE_DEPTH; i++) begin
            send_aw(addr_t'(i) << 3, 3'd3, 8'd0, id_t'(i));  // last one is dropped
        end
        inj_overflow++;
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            send_burst(addr_t'(i) << 3, 3'd3, 0, -1);
        end
        for (int i = 0; i <= QUEUE_DEPTH; i++) begin
            send_b(id_t'(i));
        end
        repeat (3) @(negedge clk_i);
        check_count("burst_done_o pulses", cnt_done, len_t'(bursts_sent));
        check_count("err_wlast_o pulses", cnt_wlast, len_t'(inj_wlast));
        check_count("err_strb_o pulses", cnt_strb, len_t'(inj_strb));
        check_count("err_id_reuse_o pulses", cnt_reuse, len_t'(inj_reuse));
        check_count("err_bresp_o pulses", cnt_bresp, len_t'(inj_bresp));
        check_count("err_orphan_o pulses", cnt_orphan, len_t'(inj_orphan));
        check_count("err_overflow_o pulses", cnt_overflow, len_t'(inj_overflow));
        $display("Summary: %0d flag errors, %0d count errors", flag_errs, count_errs);
        if (flag_errs + count_errs == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
